// ==== tl_mem_slave.f ====
src/tl_mem_pkg.sv
src/reset_stretch.sv
src/pma_lookup.sv
src/dtim_ram.sv
src/tl_beat_engine.sv
src/tl_mem_slave.sv
tests/tl_mem_slave_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tl_mem_slave_tb
FILELIST ?= tl_mem_slave.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps
SOURCES := $(wildcard src/*.sv) $(wildcard tests/*.sv)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tl_mem_slave_tb.sv ====
`timescale 1ns/10ps

module tl_mem_slave_tb
	import tl_mem_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 4000; // Tests need well under a thousand cycles

	logic clock = 1'b0;
	logic reset;
	logic a_valid;
	logic a_ready;
	logic [OPCODE_W-1:0] a_opcode;
	logic [SIZE_W-1:0] a_size;
	logic a_source;
	logic [ADDR_W-1:0] a_address;
	logic [MASK_W-1:0] a_mask;
	logic [XLEN-1:0] a_data;
	logic d_valid;
	logic d_ready;
	logic [OPCODE_W-1:0] d_opcode;
	logic [SIZE_W-1:0] d_size;
	logic d_source;
	logic [XLEN-1:0] d_data;
	logic d_denied;
	logic d_corrupt;

	integer seed = 32'h509f80aa;
	int cycle_count = 0;
	int since_reset = 0;
	logic next_source = 1'b0;
	logic [XLEN-1:0] model [RAM_WORDS]; // Expected dtim contents

	tl_mem_slave dut0 (
		.clock     (clock),
		.reset     (reset),
		.a_valid   (a_valid),
		.a_ready   (a_ready),
		.a_opcode  (a_opcode),
		.a_size    (a_size),
		.a_source  (a_source),
		.a_address (a_address),
		.a_mask    (a_mask),
		.a_data    (a_data),
		.d_valid   (d_valid),
		.d_ready   (d_ready),
		.d_opcode  (d_opcode),
		.d_size    (d_size),
		.d_source  (d_source),
		.d_data    (d_data),
		.d_denied  (d_denied),
		.d_corrupt (d_corrupt)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	// Cycles since external reset fell
	always @(posedge clock) begin
		if (reset) begin
			since_reset <= 0;
		end else if (since_reset < 15) begin
			since_reset <= since_reset + 1;
		end
	end

	task automatic value_error(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] expected);
		$display("ERROR %s got 0x%h expected 0x%h", name, got, expected);
		$display("Result: FAILED");
		$fatal(1, "value mismatch");
	endtask

	task automatic protocol_error(input string what);
		$display("Protocol failure: %s", what);
		$display("Result: FAILED");
		$fatal(1, "protocol failure");
	endtask

	task automatic expect_value(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] expected);
		assert (got === expected) else value_error(name, got, expected);
	endtask

	reset_quiet: assert property (@(posedge clock)
		(reset || since_reset < RESET_HOLD) |-> !a_ready && !d_valid)
		else protocol_error("a_ready or d_valid high during the reset hold");

	reset_release: assert property (@(posedge clock)
		(!reset && since_reset == RESET_HOLD) |-> a_ready)
		else protocol_error("a_ready still low after the reset hold");

	beat_held: assert property (@(posedge clock) disable iff (reset)
		d_valid && !d_ready |=> d_valid && $stable(d_data) && $stable(d_opcode)
			&& $stable(d_size) && $stable(d_source) && $stable(d_denied)
			&& $stable(d_corrupt))
		else protocol_error("D beat dropped or changed while stalled");

	stall_blocks_a: assert property (@(posedge clock) disable iff (reset)
		d_valid && !d_ready |-> !a_ready)
		else protocol_error("a_ready high while a response is stalled");

	corrupt_denied: assert property (@(posedge clock) disable iff (reset)
		d_valid && d_corrupt |-> d_denied)
		else protocol_error("d_corrupt set on a beat that is not denied");

	function automatic int beat_total(input logic [OPCODE_W-1:0] opcode,
			input logic [SIZE_W-1:0] size);
		int clamped;
		if (opcode != OP_A_GET) begin
			return 1;
		end
		clamped = (size > MAX_GET_SIZE) ? MAX_GET_SIZE : int'(size); // Oversized Gets clamp
		return ((1 << clamped) > BEAT_BYTES) ? (1 << clamped) / BEAT_BYTES : 1;
	endfunction

	function automatic logic in_dtim(input logic [ADDR_W-1:0] address);
		return address >= REGION_BASE[DTIM_INDEX] && address < REGION_END[DTIM_INDEX];
	endfunction

	function automatic logic [RAM_ADDR_W-1:0] word_index(input logic [ADDR_W-1:0] address,
			input int beat);
		return RAM_ADDR_W'(address >> 2) + RAM_ADDR_W'(beat);
	endfunction

	task automatic apply_reset();
		reset = 1'b1;
		repeat (4) @(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < RESET_HOLD; i++) begin
			#1;
			expect_value("a_ready", 32'(a_ready), 32'd0);
			@(negedge clock);
		end
		#1;
		expect_value("a_ready", 32'(a_ready), 32'd1);
	endtask

	// One request and all of its beats under random back-pressure
	task automatic transact(input logic [OPCODE_W-1:0] opcode, input logic [SIZE_W-1:0] size,
			input logic [ADDR_W-1:0] address, input logic [MASK_W-1:0] mask,
			input logic [XLEN-1:0] data, input logic denied);
		int beats;
		int beat;
		logic is_get;
		logic is_put;
		logic source;
		logic [XLEN-1:0] expected;
		logic [RAM_ADDR_W-1:0] index;

		beats = beat_total(opcode, size);
		is_get = opcode == OP_A_GET;
		is_put = opcode == OP_A_PUTFULL || opcode == OP_A_PUTPARTIAL;
		source = next_source;
		next_source = !next_source;

		@(negedge clock);
		a_valid = 1'b1;
		a_opcode = opcode;
		a_size = size;
		a_source = source;
		a_address = address;
		a_mask = mask;
		a_data = data;
		#1;
		while (!a_ready) begin
			@(negedge clock);
			#1;
		end
		@(posedge clock);

		if (is_put && !denied && in_dtim(address)) begin
			index = word_index(address, 0);
			for (int b = 0; b < MASK_W; b++) begin
				if (mask[b]) begin
					model[index][8*b +: 8] = data[8*b +: 8];
				end
			end
		end

		beat = 0;
		while (beat < beats) begin
			@(negedge clock);
			a_valid = 1'b0;
			d_ready = ($random(seed) & 3) != 0;
			#1;
			assert (d_valid) else protocol_error("d_valid low while a beat is owed");
			expected = '0;
			if (is_get && !denied && in_dtim(address)) begin
				expected = model[word_index(address, beat)];
			end
			expect_value("d_opcode", 32'(d_opcode),
				is_get ? 32'(OP_D_ACCESSACKDATA) : 32'(OP_D_ACCESSACK));
			expect_value("d_size", 32'(d_size), 32'(size));
			expect_value("d_source", 32'(d_source), 32'(source));
			expect_value("d_denied", 32'(d_denied), 32'(denied));
			expect_value("d_corrupt", 32'(d_corrupt), 32'(is_get && denied));
			expect_value("d_data", d_data, expected);
			expect_value("a_ready", 32'(a_ready), 32'(d_ready && beat == beats - 1));
			if (d_ready) begin
				beat++;
			end
		end
	endtask

	initial begin
		logic [ADDR_W-1:0] addr;

		a_valid = 1'b0;
		a_opcode = '0;
		a_size = '0;
		a_source = 1'b0;
		a_address = '0;
		a_mask = '0;
		a_data = '0;
		d_ready = 1'b0;
		for (int i = 0; i < RAM_WORDS; i++) begin
			model[i] = '0;
		end
		apply_reset();

		// Bottom and top of dtim
		for (int i = 0; i < 16; i++) begin
			transact(OP_A_PUTFULL, 4'd2, 32'h8000_0000 + 32'(4 * i), 4'hf, $random(seed), 1'b0);
		end
		for (int i = 0; i < 4; i++) begin
			transact(OP_A_PUTFULL, 4'd2, 32'h8000_3ff0 + 32'(4 * i), 4'hf, $random(seed), 1'b0);
		end

		transact(OP_A_PUTPARTIAL, 4'd0, 32'h8000_0005, 4'b0010, $random(seed), 1'b0);
		transact(OP_A_PUTPARTIAL, 4'd1, 32'h8000_000a, 4'b1100, $random(seed), 1'b0);
		transact(OP_A_PUTPARTIAL, 4'd2, 32'h8000_0010, 4'b1001, $random(seed), 1'b0);
		transact(OP_A_PUTFULL, 4'd1, 32'h8000_0016, 4'b1100, $random(seed), 1'b0);

		transact(OP_A_GET, 4'd0, 32'h8000_0005, 4'b0010, '0, 1'b0);
		transact(OP_A_GET, 4'd1, 32'h8000_000a, 4'b1100, '0, 1'b0);
		transact(OP_A_GET, 4'd2, 32'h8000_0010, 4'hf, '0, 1'b0);
		transact(OP_A_GET, 4'd3, 32'h8000_0008, 4'hf, '0, 1'b0);
		transact(OP_A_GET, 4'd4, 32'h8000_0000, 4'hf, '0, 1'b0);
		transact(OP_A_GET, 4'd4, 32'h8000_3ff0, 4'hf, '0, 1'b0);

		for (int i = 0; i < 24; i++) begin
			addr = 32'h8000_0000 + 32'(($random(seed) & 15) * 4);
			transact(OP_A_PUTPARTIAL, 4'd2, addr, 4'($random(seed)), $random(seed), 1'b0);
			transact(OP_A_GET, 4'd4, addr & ~32'hf, 4'hf, '0, 1'b0);
		end

		transact(OP_A_PUTFULL, 4'd2, 32'h0001_0000, 4'hf, $random(seed), 1'b1); // rom
		transact(OP_A_GET, 4'd2, 32'h0001_0000, 4'hf, '0, 1'b0);
		transact(OP_A_GET, 4'd2, 32'h0000_5000, 4'hf, '0, 1'b1); // Unmapped
		transact(OP_A_GET, 4'd2, 32'h8000_0002, 4'hf, '0, 1'b1);
		transact(OP_A_GET, 4'd3, 32'h8000_3ffc, 4'hf, '0, 1'b1); // Runs past dtim end
		transact(OP_A_GET, 4'd5, 32'h8000_0000, 4'hf, '0, 1'b1);
		transact(OP_A_PUTFULL, 4'd3, 32'h8000_0000, 4'hf, $random(seed), 1'b1);
		transact(OP_A_PUTFULL, 4'd2, 32'h8000_0001, 4'hf, $random(seed), 1'b1);
		transact(OP_A_GET, 4'd3, 32'h8000_0000, 4'hf, '0, 1'b0);

		transact(OP_A_GET, 4'd3, 32'h6000_0100, 4'hf, '0, 1'b0);
		transact(OP_A_GET, 4'd4, 32'h0c00_0000, 4'hf, '0, 1'b0);
		transact(OP_A_ARITH, 4'd2, 32'h8000_0000, 4'hf, $random(seed), 1'b1);
		transact(OP_A_LOGICAL, 4'd2, 32'h8000_0004, 4'hf, $random(seed), 1'b1);
		transact(OP_A_INTENT, 4'd2, 32'h8000_0008, 4'hf, '0, 1'b1);
		transact(OP_A_GET, 4'd4, 32'h8000_0000, 4'hf, '0, 1'b0);

		repeat (2) @(negedge clock);
		assert (!d_valid) else protocol_error("d_valid high with no request pending");
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== src/tl_mem_slave.sv ====
`timescale 1ns/10ps

module tl_mem_slave
	import tl_mem_pkg::*;
(
	input  logic clock,
	input  logic reset,

	input  logic a_valid,
	output logic a_ready,
	input  logic [OPCODE_W-1:0] a_opcode,
	input  logic [SIZE_W-1:0] a_size,
	input  logic a_source,
	input  logic [ADDR_W-1:0] a_address,
	input  logic [MASK_W-1:0] a_mask,
	input  logic [XLEN-1:0] a_data,

	output logic d_valid,
	input  logic d_ready,
	output logic [OPCODE_W-1:0] d_opcode,
	output logic [SIZE_W-1:0] d_size,
	output logic d_source,
	output logic [XLEN-1:0] d_data,
	output logic d_denied,
	output logic d_corrupt
);

	logic internal_reset;
	logic readable, writable, backed;

	logic wr_en;
	logic [RAM_ADDR_W-1:0] wr_index;
	logic [MASK_W-1:0] wr_mask;
	logic [XLEN-1:0] wr_data;
	logic [RAM_ADDR_W-1:0] rd_index;
	logic [XLEN-1:0] rd_data;

	reset_stretch reset_stretch0 (
		.clock          (clock),
		.reset          (reset),
		.internal_reset (internal_reset)
	);

	// Checks the live A request
	pma_lookup pma_lookup0 (
		.address  (a_address),
		.size     (a_size),
		.readable (readable),
		.writable (writable),
		.backed   (backed)
	);

	tl_beat_engine tl_beat_engine0 (
		.clock          (clock),
		.internal_reset (internal_reset),
		.a_valid        (a_valid),
		.a_ready        (a_ready),
		.a_opcode       (a_opcode),
		.a_size         (a_size),
		.a_source       (a_source),
		.a_address      (a_address),
		.a_mask         (a_mask),
		.a_data         (a_data),
		.readable       (readable),
		.writable       (writable),
		.backed         (backed),
		.d_valid        (d_valid),
		.d_ready        (d_ready),
		.d_opcode       (d_opcode),
		.d_size         (d_size),
		.d_source       (d_source),
		.d_data         (d_data),
		.d_denied       (d_denied),
		.d_corrupt      (d_corrupt),
		.wr_en          (wr_en),
		.wr_index       (wr_index),
		.wr_mask        (wr_mask),
		.wr_data        (wr_data),
		.rd_index       (rd_index),
		.rd_data        (rd_data)
	);

	dtim_ram dtim_ram0 (
		.clock    (clock),
		.wr_en    (wr_en),
		.wr_index (wr_index),
		.wr_mask  (wr_mask),
		.wr_data  (wr_data),
		.rd_index (rd_index),
		.rd_data  (rd_data)
	);

endmodule

// ==== src/tl_beat_engine.sv ====
`timescale 1ns/10ps

module tl_beat_engine
	import tl_mem_pkg::*;
(
	input  logic clock,
	input  logic internal_reset,

	input  logic a_valid,
	output logic a_ready,
	input  logic [OPCODE_W-1:0] a_opcode,
	input  logic [SIZE_W-1:0] a_size,
	input  logic a_source,
	input  logic [ADDR_W-1:0] a_address,
	input  logic [MASK_W-1:0] a_mask,
	input  logic [XLEN-1:0] a_data,

	input  logic readable,
	input  logic writable,
	input  logic backed,

	output logic d_valid,
	input  logic d_ready,
	output logic [OPCODE_W-1:0] d_opcode,
	output logic [SIZE_W-1:0] d_size,
	output logic d_source,
	output logic [XLEN-1:0] d_data,
	output logic d_denied,
	output logic d_corrupt,

	output logic wr_en,
	output logic [RAM_ADDR_W-1:0] wr_index,
	output logic [MASK_W-1:0] wr_mask,
	output logic [XLEN-1:0] wr_data,

	output logic [RAM_ADDR_W-1:0] rd_index,
	input  logic [XLEN-1:0] rd_data
);

	localparam int OFFSET_W = $clog2(BEAT_BYTES);

	logic busy;
	logic [BEAT_CNT_W-1:0] beat_count;
	logic [BEAT_CNT_W-1:0] final_count;
	logic last_beat;
	logic a_fire, d_fire;

	logic is_put;
	logic deny;
	logic [RAM_ADDR_W-1:0] a_index;
	logic [SIZE_W-1:0] get_size;

	// Request held for the response
	logic [OPCODE_W-1:0] op_opcode;
	logic [SIZE_W-1:0] op_size;
	logic op_source;
	logic [RAM_ADDR_W-1:0] op_index;
	logic op_denied;
	logic op_backed;
	logic op_is_get;

	assign a_fire = a_valid && a_ready;
	assign d_fire = d_valid && d_ready;

	assign is_put = a_opcode == OP_A_PUTFULL || a_opcode == OP_A_PUTPARTIAL;
	assign a_index = a_address[OFFSET_W +: RAM_ADDR_W]; // wraps modulo RAM_WORDS

	always_comb begin
		case (a_opcode)
			OP_A_GET:
				deny = a_size > SIZE_W'(MAX_GET_SIZE) || !readable;
			OP_A_PUTFULL, OP_A_PUTPARTIAL:
				deny = a_size > SIZE_W'(MAX_PUT_SIZE) || !writable;
			default:
				deny = 1'b1; // Arithmetic, Logical and Intent get a single denied ack
		endcase
	end

	assign a_ready = !internal_reset && (!busy || (d_fire && last_beat));

	// Oversized Gets are denied and clamped to the largest burst
	assign op_is_get = op_opcode == OP_A_GET;
	assign get_size = (op_size > SIZE_W'(MAX_GET_SIZE)) ? SIZE_W'(MAX_GET_SIZE) : op_size;

	always_comb begin
		if (op_is_get && get_size > SIZE_W'(OFFSET_W)) begin
			final_count = BEAT_CNT_W'((1 << (get_size - SIZE_W'(OFFSET_W))) - 1);
		end else begin
			final_count = '0;
		end
	end

	assign last_beat = beat_count == final_count;

	always_ff @(posedge clock) begin
		if (internal_reset) begin
			busy <= 1'b0;
			beat_count <= '0;
		end else begin
			if (d_fire) begin
				if (last_beat) begin
					busy <= 1'b0;
				end else begin
					beat_count <= beat_count + 1'b1;
				end
			end
			if (a_fire) begin // may overlap the final beat
				busy <= 1'b1;
				beat_count <= '0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (a_fire) begin
			op_opcode <= a_opcode;
			op_size <= a_size;
			op_source <= a_source;
			op_index <= a_index;
			op_denied <= deny;
			op_backed <= backed;
		end
	end

	assign d_valid = busy;
	assign d_opcode = op_is_get ? OP_D_ACCESSACKDATA : OP_D_ACCESSACK;
	assign d_size = op_size;
	assign d_source = op_source;
	assign d_denied = op_denied;
	assign d_corrupt = op_is_get && op_denied;

	assign rd_index = op_index + RAM_ADDR_W'(beat_count);
	assign d_data = (op_is_get && !op_denied && op_backed) ? rd_data : '0;

	// Puts land in RAM at the acceptance edge
	assign wr_en = a_fire && is_put && !deny && backed;
	assign wr_index = a_index;
	assign wr_mask = a_mask;
	assign wr_data = a_data;

endmodule

// ==== src/dtim_ram.sv ====
`timescale 1ns/10ps

module dtim_ram
	import tl_mem_pkg::*;
(
	input  logic clock,
	input  logic wr_en,
	input  logic [RAM_ADDR_W-1:0] wr_index,
	input  logic [MASK_W-1:0] wr_mask,
	input  logic [XLEN-1:0] wr_data,
	input  logic [RAM_ADDR_W-1:0] rd_index,
	output logic [XLEN-1:0] rd_data
);

	logic [XLEN-1:0] mem [RAM_WORDS];

	// Byte lanes written independently
	always_ff @(posedge clock) begin
		if (wr_en) begin
			for (int b = 0; b < MASK_W; b++) begin
				if (wr_mask[b]) begin
					mem[wr_index][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
	end

	assign rd_data = mem[rd_index]; // Asynchronous read

endmodule

// ==== src/pma_lookup.sv ====
`timescale 1ns/10ps

module pma_lookup
	import tl_mem_pkg::*;
(
	input  logic [ADDR_W-1:0] address,
	input  logic [SIZE_W-1:0] size,
	output logic readable,
	output logic writable,
	output logic backed
);

	// One extra bit so the last byte cannot wrap into low regions
	logic [ADDR_W:0] first_address;
	logic [ADDR_W:0] last_address;
	logic [ADDR_W:0] offset_mask;
	logic first_r, first_w;
	logic last_r, last_w;
	logic misaligned;

	function automatic logic in_region(input logic [ADDR_W:0] addr, input int index);
		return addr >= {1'b0, REGION_BASE[index]} && addr < {1'b0, REGION_END[index]};
	endfunction

	assign first_address = {1'b0, address};
	assign offset_mask = (ADDR_W + 1)'((64'd1 << size) - 64'd1);
	assign last_address = first_address + offset_mask;
	assign misaligned = (first_address & offset_mask) != '0;

	always_comb begin
		first_r = 1'b0;
		first_w = 1'b0;
		last_r = 1'b0;
		last_w = 1'b0;
		for (int i = 0; i < REGION_COUNT; i++) begin
			if (in_region(first_address, i)) begin
				first_r = REGION_R[i];
				first_w = REGION_W[i];
			end
			if (in_region(last_address, i)) begin
				last_r = REGION_R[i];
				last_w = REGION_W[i];
			end
		end
	end

	// Spanning a boundary loses both permissions
	assign readable = first_r && last_r && !misaligned;
	assign writable = first_w && last_w && !misaligned;

	assign backed = in_region(first_address, DTIM_INDEX);

endmodule

// ==== src/reset_stretch.sv ====
`timescale 1ns/10ps

module reset_stretch
	import tl_mem_pkg::*;
(
	input  logic clock,
	input  logic reset,
	output logic internal_reset
);

	logic [HOLD_CNT_W-1:0] hold_count;

	// Reloads while reset is high, then drains to zero
	always_ff @(posedge clock) begin
		if (reset) begin
			hold_count <= HOLD_CNT_W'(RESET_HOLD);
		end else if (hold_count != '0) begin
			hold_count <= hold_count - 1'b1;
		end
	end

	// Rises with reset in the same cycle
	assign internal_reset = reset || (hold_count != '0);

endmodule

// ==== src/tl_mem_pkg.sv ====
package tl_mem_pkg;

	// Bus widths
	localparam int XLEN = 32;
	localparam int BEAT_BYTES = XLEN / 8;
	localparam int MASK_W = BEAT_BYTES;
	localparam int ADDR_W = 32;
	localparam int SIZE_W = 4;
	localparam int OPCODE_W = 3;

	localparam int MAX_GET_SIZE = 4; // 16 bytes, 4 beats
	localparam int MAX_PUT_SIZE = 2; // single beat

	// dtim backing store, 16 KB
	localparam int RAM_WORDS = 4096;
	localparam int RAM_ADDR_W = 12;
	localparam int BEAT_CNT_W = 2;

	localparam int RESET_HOLD = 5;
	localparam int HOLD_CNT_W = 3;

	// A channel opcodes
	localparam logic [OPCODE_W-1:0] OP_A_PUTFULL = 3'd0;
	localparam logic [OPCODE_W-1:0] OP_A_PUTPARTIAL = 3'd1;
	localparam logic [OPCODE_W-1:0] OP_A_ARITH = 3'd2;
	localparam logic [OPCODE_W-1:0] OP_A_LOGICAL = 3'd3;
	localparam logic [OPCODE_W-1:0] OP_A_GET = 3'd4;
	localparam logic [OPCODE_W-1:0] OP_A_INTENT = 3'd5;

	// D channel opcodes
	localparam logic [OPCODE_W-1:0] OP_D_ACCESSACK = 3'd0;
	localparam logic [OPCODE_W-1:0] OP_D_ACCESSACKDATA = 3'd1;

	// Address map, end is exclusive
	localparam int REGION_COUNT = 7;

	localparam logic [ADDR_W-1:0] REGION_BASE [REGION_COUNT] = '{
		32'h0000_0000, // debug
		32'h0000_3000, // error device
		32'h0001_0000, // rom
		32'h0200_0000, // clint
		32'h0c00_0000, // interrupt controller
		32'h6000_0000, // mmio
		32'h8000_0000  // dtim
	};

	localparam logic [ADDR_W-1:0] REGION_END [REGION_COUNT] = '{
		32'h0000_1000,
		32'h0000_4000,
		32'h0002_0000,
		32'h0201_0000,
		32'h1000_0000,
		32'h8000_0000,
		32'h8000_4000
	};

	// Bit i belongs to region i
	localparam logic [REGION_COUNT-1:0] REGION_R = 7'b111_1111;
	localparam logic [REGION_COUNT-1:0] REGION_W = 7'b111_1011; // rom is read only

	localparam int DTIM_INDEX = 6;

endpackage
